/* design/beam_sort_pkg.sv */
/*
 * Shared sizes and types for the column beam sorter.
 * Every design module imports this package by wildcard.
 */
package beam_sort_pkg;

    // Column and beam sizes
    localparam int COL       = 64;
    localparam int DATA_W    = 32;
    localparam int NUM_BEAMS = 16;
    localparam int NUM_RBG   = 16;

    localparam int INDEX_W = $clog2(COL);
    localparam int SLOT_W  = $clog2(NUM_RBG);

    // ------------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------------
    typedef logic [DATA_W-1:0]  data_t;
    typedef data_t [COL-1:0]    col_t;
    typedef logic [INDEX_W-1:0] score_t;
    typedef score_t [COL-1:0]   score_vec_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [SLOT_W-1:0]  slot_t;

    // Top beams in score order, position 0 holds the largest sample
    typedef struct packed {
        data_t  [NUM_BEAMS-1:0] data;
        index_t [NUM_BEAMS-1:0] index;
    } beam_rec_t;

    // Control FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RANK,
        ST_SCATTER,
        ST_WRITE
    } ctrl_state_t;

endpackage

/* design/rank_lane.sv */
/*
 * One ranking lane: scores the sample at i_index against the whole column.
 * Score is the count of larger samples plus equal samples at a lower index.
 */
module rank_lane
    import beam_sort_pkg::*;
(
    input  logic   i_clk,
    input  col_t   i_col,
    input  index_t i_index,
    input  logic   i_en,
    output score_t o_score
);

    data_t  sample;
    score_t count;

    assign sample = i_col[i_index];

    // Comparison against every column entry, self never counts
    always_comb begin
        score_t cnt;
        logic   beats;
        cnt = '0;
        for (int j = 0; j < COL; j++) begin
            beats = (i_col[j] > sample) ||
                    ((i_col[j] == sample) && (index_t'(j) < i_index));
            if (beats) begin
                cnt = cnt + score_t'(1);
            end
        end
        count = cnt;
    end

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_score <= count;
        end
    end

endmodule

/* design/sort_scatter.sv */
/*
 * Collects lane scores into the full score vector and, on build, scatters
 * the top samples and their column indices into a beam record.
 */
module sort_scatter
    import beam_sort_pkg::*;
#(
    parameter int LANES = 4
) (
    input  logic               i_clk,
    input  col_t               i_col,
    input  logic               i_score_wr,
    input  index_t             i_score_base,
    input  score_t [LANES-1:0] i_lane_scores,
    input  logic               i_build,
    output score_vec_t         o_score,
    output beam_rec_t          o_rec
);

    // Record position width
    localparam int POS_W = $clog2(NUM_BEAMS);

    // ------------------------------------------------------------------
    // Score store, one lane group per write
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_score_wr) begin
            for (int l = 0; l < LANES; l++) begin
                o_score[i_score_base + index_t'(l)] <= i_lane_scores[l];
            end
        end
    end

    // ------------------------------------------------------------------
    // Scatter into score order
    // ------------------------------------------------------------------
    // Scores form a permutation, so each kept position gets one writer
    always_ff @(posedge i_clk) begin
        score_t s;
        if (i_build) begin
            for (int i = 0; i < COL; i++) begin
                s = o_score[i];
                if (s < score_t'(NUM_BEAMS)) begin
                    o_rec.data[s[POS_W-1:0]]  <= i_col[i];
                    o_rec.index[s[POS_W-1:0]] <= index_t'(i);
                end
            end
        end
    end

endmodule

/* design/beam_mem.sv */
/*
 * Beam record memory, one slot per resource block group.
 * Registered read followed by an output stage, two cycles from read enable.
 */
module beam_mem
    import beam_sort_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   reset_syn,
    input  logic                   i_wr_en,
    input  slot_t                  i_wr_slot,
    input  beam_rec_t              i_rec,
    input  logic                   i_rd_en,
    input  slot_t                  i_rd_slot,
    output data_t  [NUM_BEAMS-1:0] o_data,
    output index_t [NUM_BEAMS-1:0] o_beam_index,
    output slot_t                  o_rbg_num,
    output logic                   o_rbg_load
);

    beam_rec_t mem [NUM_RBG];
    beam_rec_t rd_rec;
    slot_t     rd_slot_q;
    logic      rd_vld;

    // Read of a slot written on the same edge sees the old record
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_slot] <= i_rec;
        end
        if (i_rd_en) begin
            rd_rec    <= mem[i_rd_slot];
            rd_slot_q <= i_rd_slot;
        end
    end

    // ------------------------------------------------------------------
    // Output stage, held until the next read
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (reset_syn) begin
            rd_vld       <= 1'b0;
            o_rbg_load   <= 1'b0;
            o_data       <= '0;
            o_beam_index <= '0;
            o_rbg_num    <= '0;
        end else begin
            rd_vld     <= i_rd_en;
            o_rbg_load <= rd_vld;
            if (rd_vld) begin
                o_data       <= rd_rec.data;
                o_beam_index <= rd_rec.index;
                o_rbg_num    <= rd_slot_q;
            end
        end
    end

endmodule

/* design/sort_ctrl.sv */
/*
 * Sort sequencing FSM with the column base counter and the rotating
 * write and read slot counters for the record memory.
 */
module sort_ctrl
    import beam_sort_pkg::*;
#(
    parameter int LANES = 4
) (
    input  logic   i_clk,
    input  logic   reset_syn,
    input  logic   i_sort_start,
    input  slot_t  i_rbg_max,
    input  logic   i_rbg_load,
    output logic   o_capture,
    output logic   o_rank_en,
    output index_t o_base,
    output logic   o_score_wr,
    output index_t o_score_base,
    output logic   o_build,
    output logic   o_wr_en,
    output slot_t  o_wr_slot,
    output logic   o_rd_en,
    output slot_t  o_rd_slot,
    output logic   o_sort_done
);

    // Base of the final lane group
    localparam index_t LAST_BASE = index_t'(COL - LANES);

    ctrl_state_t state;
    slot_t       rd_slot;

    // Slot after s, back to 0 once the group limit is reached
    function automatic slot_t next_slot(input slot_t s, input slot_t max);
        if (s >= max) begin
            return '0;
        end
        return s + slot_t'(1);
    endfunction

    // Start is only taken while idle
    assign o_capture = (state == ST_IDLE) && i_sort_start;
    assign o_rank_en = (state == ST_RANK);

    // ------------------------------------------------------------------
    // FSM and column base
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (reset_syn) begin
            state  <= ST_IDLE;
            o_base <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    o_base <= '0;
                    if (i_sort_start) begin
                        state <= ST_RANK;
                    end
                end
                ST_RANK: begin
                    if (o_base == LAST_BASE) begin
                        state <= ST_SCATTER;
                    end else begin
                        o_base <= o_base + index_t'(LANES);
                    end
                end
                ST_SCATTER: state <= ST_WRITE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Strobes trail the state by one cycle to line up with the lane registers
    always_ff @(posedge i_clk) begin
        if (reset_syn) begin
            o_score_wr  <= 1'b0;
            o_build     <= 1'b0;
            o_wr_en     <= 1'b0;
            o_sort_done <= 1'b0;
        end else begin
            o_score_wr  <= o_rank_en;
            o_build     <= (state == ST_SCATTER);
            o_wr_en     <= (state == ST_WRITE);
            o_sort_done <= o_wr_en;
        end
    end

    always_ff @(posedge i_clk) begin
        o_score_base <= o_base;
    end

    // ------------------------------------------------------------------
    // Slot counters
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (reset_syn) begin
            o_wr_slot <= '0;
            rd_slot   <= '0;
            o_rd_slot <= '0;
            o_rd_en   <= 1'b0;
        end else begin
            o_rd_en <= i_rbg_load;
            if (o_wr_en) begin
                o_wr_slot <= next_slot(o_wr_slot, i_rbg_max);
            end
            if (i_rbg_load) begin
                o_rd_slot <= rd_slot;
                rd_slot   <= next_slot(rd_slot, i_rbg_max);
            end
        end
    end

endmodule

/* design/beam_sort_top.sv */
/*
 * Top level of the beam sorter: captures a column, ranks it LANES samples
 * per cycle, keeps the top beams per resource block group and reads them back.
 */
module beam_sort_top
    import beam_sort_pkg::*;
#(
    parameter int LANES = 4
) (
    input  logic                   i_clk,
    input  logic                   reset_syn,
    input  col_t                   i_data,
    input  logic                   i_sort_start,
    input  slot_t                  i_rbg_max,
    input  logic                   i_rbg_load,
    output score_vec_t             o_score,
    output data_t  [NUM_BEAMS-1:0] o_data,
    output index_t [NUM_BEAMS-1:0] o_beam_index,
    output slot_t                  o_rbg_num,
    output logic                   o_rbg_load,
    output logic                   o_sort_done
);

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    logic   capture;
    logic   rank_en;
    index_t base;
    logic   score_wr;
    index_t score_base;
    logic   build;
    logic   wr_en;
    slot_t  wr_slot;
    logic   rd_en;
    slot_t  rd_slot;

    col_t                 col_q;
    score_t [LANES-1:0]   lane_score;
    beam_rec_t            rec;

    sort_ctrl #(
        .LANES (LANES)
    ) u_ctrl (
        .i_clk        (i_clk),
        .reset_syn    (reset_syn),
        .i_sort_start (i_sort_start),
        .i_rbg_max    (i_rbg_max),
        .i_rbg_load   (i_rbg_load),
        .o_capture    (capture),
        .o_rank_en    (rank_en),
        .o_base       (base),
        .o_score_wr   (score_wr),
        .o_score_base (score_base),
        .o_build      (build),
        .o_wr_en      (wr_en),
        .o_wr_slot    (wr_slot),
        .o_rd_en      (rd_en),
        .o_rd_slot    (rd_slot),
        .o_sort_done  (o_sort_done)
    );

    // Column held for the whole sort, shared by all lanes
    always_ff @(posedge i_clk) begin
        if (capture) begin
            col_q <= i_data;
        end
    end

    // ------------------------------------------------------------------
    // Ranking lanes, lane k scores column base + k
    // ------------------------------------------------------------------
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        rank_lane u_lane (
            .i_clk   (i_clk),
            .i_col   (col_q),
            .i_index (base + index_t'(k)),
            .i_en    (rank_en),
            .o_score (lane_score[k])
        );
    end

    sort_scatter #(
        .LANES (LANES)
    ) u_scatter (
        .i_clk         (i_clk),
        .i_col         (col_q),
        .i_score_wr    (score_wr),
        .i_score_base  (score_base),
        .i_lane_scores (lane_score),
        .i_build       (build),
        .o_score       (o_score),
        .o_rec         (rec)
    );

    beam_mem u_mem (
        .i_clk        (i_clk),
        .reset_syn    (reset_syn),
        .i_wr_en      (wr_en),
        .i_wr_slot    (wr_slot),
        .i_rec        (rec),
        .i_rd_en      (rd_en),
        .i_rd_slot    (rd_slot),
        .o_data       (o_data),
        .o_beam_index (o_beam_index),
        .o_rbg_num    (o_rbg_num),
        .o_rbg_load   (o_rbg_load)
    );

endmodule

/* bench/beam_sort_tb.sv */
/*
 * Testbench for the beam sorter with LFSR columns full of ties and a timed
 * reference model. Concurrent checks run on the falling edge, then a report.
 */
module beam_sort_tb
    import beam_sort_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SORT_LAT = COL / 4 + 3;
    // Eight sorts of SORT_LAT cycles and the read-outs take about 250 cycles
    localparam int TIMEOUT_CYC = 2000;

    logic                   i_clk;
    logic                   reset_syn;
    col_t                   i_data;
    logic                   i_sort_start;
    slot_t                  i_rbg_max;
    logic                   i_rbg_load;
    score_vec_t             o_score;
    data_t  [NUM_BEAMS-1:0] o_data;
    index_t [NUM_BEAMS-1:0] o_beam_index;
    slot_t                  o_rbg_num;
    logic                   o_rbg_load;
    logic                   o_sort_done;

    logic [31:0] lfsr_q = 32'h0aa9_1c74;
    int          error_count = 0;
    int          errors_before = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;

    // Reference model state
    int         ref_cnt;
    col_t       ref_col;
    slot_t      ref_wr_slot;
    slot_t      ref_rd_slot;
    beam_rec_t  ref_mem [NUM_RBG];
    logic       rd_req;
    slot_t      rd_req_slot;
    logic       rd_hit;
    slot_t      rd_hit_slot;
    beam_rec_t  rd_hit_rec;
    logic       exp_done;
    logic       exp_load;
    score_vec_t exp_score;
    beam_rec_t  exp_rec;
    slot_t      exp_num;

    beam_sort_top uut (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function void flag_error(input string msg);
        error_count++;
        $display("ERROR %0t ns: %s", $time, msg);
    endfunction

    // Galois LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function logic [3:0] random_nibble();
        logic [3:0] v;
        for (int b = 0; b < 4; b++) begin
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
            v[b] = lfsr_q[0];
        end
        return v;
    endfunction

    // Only 16 distinct values per column, so ties are common
    function col_t random_column();
        col_t       c;
        logic [3:0] nib;
        for (int i = 0; i < COL; i++) begin
            nib = random_nibble();
            c[i] = {8{nib}};
        end
        return c;
    endfunction

    // Each pass takes the largest sample left and the lowest index among equals
    function automatic score_vec_t rank_scores(input col_t c);
        score_vec_t     s;
        logic [COL-1:0] taken;
        int             best;
        taken = '0;
        for (int p = 0; p < COL; p++) begin
            best = -1;
            for (int j = 0; j < COL; j++) begin
                if (!taken[j] && (best < 0 || c[j] > c[best])) begin
                    best = j;
                end
            end
            taken[best] = 1'b1;
            s[best]     = score_t'(p);
        end
        return s;
    endfunction

    // Repeated max search where the strict compare keeps the lower index on ties
    function automatic beam_rec_t pick_top_beams(input col_t c);
        beam_rec_t      r;
        logic [COL-1:0] taken;
        int             best;
        taken = '0;
        for (int p = 0; p < NUM_BEAMS; p++) begin
            best = -1;
            for (int j = 0; j < COL; j++) begin
                if (!taken[j] && (best < 0 || c[j] > c[best])) begin
                    best = j;
                end
            end
            taken[best] = 1'b1;
            r.data[p]   = c[best];
            r.index[p]  = index_t'(best);
        end
        return r;
    endfunction

    // Pairwise order check, which also forces a permutation
    function automatic bit scores_consistent(input col_t c, input score_vec_t s);
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < COL; i++) begin
            for (int j = i + 1; j < COL; j++) begin
                if (c[i] >= c[j] ? s[i] >= s[j] : s[i] <= s[j]) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    function automatic slot_t wrap_slot(input slot_t s);
        return (s >= i_rbg_max) ? '0 : s + 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    // Reference timing with done SORT_LAT edges after start and the record
    // two edges after load
    // ----------------------------------------------------------------------
    always @(posedge i_clk) begin
        if (reset_syn) begin
            ref_cnt     <= 0;
            ref_wr_slot <= '0;
            ref_rd_slot <= '0;
            rd_req      <= 1'b0;
            rd_hit      <= 1'b0;
            exp_done    <= 1'b0;
            exp_load    <= 1'b0;
            exp_rec     <= '0;
            exp_num     <= '0;
        end else begin
            exp_done <= (ref_cnt == 1);
            if (ref_cnt == 1) begin
                exp_score            <= rank_scores(ref_col);
                ref_mem[ref_wr_slot] <= pick_top_beams(ref_col);
                ref_wr_slot          <= wrap_slot(ref_wr_slot);
            end
            // Start counts only once the previous sort has left the FSM
            if (i_sort_start && ref_cnt <= 1) begin
                ref_cnt <= SORT_LAT;
                ref_col <= i_data;
            end else if (ref_cnt != 0) begin
                ref_cnt <= ref_cnt - 1;
            end
            rd_req <= i_rbg_load;
            if (i_rbg_load) begin
                rd_req_slot <= ref_rd_slot;
                ref_rd_slot <= wrap_slot(ref_rd_slot);
            end
            rd_hit <= rd_req;
            if (rd_req) begin
                rd_hit_rec  <= ref_mem[rd_req_slot];
                rd_hit_slot <= rd_req_slot;
            end
            exp_load <= rd_hit;
            if (rd_hit) begin
                exp_rec <= rd_hit_rec;
                exp_num <= rd_hit_slot;
            end
        end
    end

    a_done: assert property (@(negedge i_clk) disable iff (reset_syn)
        o_sort_done == exp_done)
        else flag_error("o_sort_done differs from the expected sort timing");
    a_load: assert property (@(negedge i_clk) disable iff (reset_syn)
        o_rbg_load == exp_load)
        else flag_error("o_rbg_load differs from the expected read timing");
    a_score: assert property (@(negedge i_clk) disable iff (reset_syn)
        exp_done |-> o_score == exp_score)
        else flag_error("o_score differs from the model scores");
    a_rec: assert property (@(negedge i_clk) disable iff (reset_syn)
        exp_load |-> o_rbg_num == exp_num && o_data == exp_rec.data
                     && o_beam_index == exp_rec.index)
        else flag_error("read-out record differs from the model");

    task automatic start_sort(output col_t c);
        @(negedge i_clk);
        c = random_column();
        i_data = c;
        i_sort_start = 1'b1;
        @(negedge i_clk);
        i_sort_start = 1'b0;
    endtask

    task automatic wait_done(output int n);
        n = 0;
        while (!o_sort_done) begin
            @(negedge i_clk);
            n++;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - errors_before;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("%-24s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
        errors_before = error_count;
    endtask

    initial begin
        col_t      col_a;
        slot_t     nums [$];
        slot_t     slot;
        beam_rec_t old_rec;
        int        n;
        int        first_k;
        reset_syn    = 1'b1;
        i_data       = '0;
        i_sort_start = 1'b0;
        i_rbg_max    = slot_t'(3);
        i_rbg_load   = 1'b0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        reset_syn = 1'b0;

        repeat (8) begin
            @(negedge i_clk);
            assert (!o_sort_done && !o_rbg_load)
                else flag_error("strobe high before the first start");
        end
        end_test("reset state");

        // Five sorts write slots 0, 1, 2, 3 and wrap to 0
        repeat (5) begin
            start_sort(col_a);
            wait_done(n);
        end
        first_k = -1;
        for (int k = 0; k < 8; k++) begin
            @(negedge i_clk);
            i_rbg_load = (k < 5);
            if (o_rbg_load) begin
                nums.push_back(o_rbg_num);
                first_k = (first_k < 0) ? k : first_k;
            end
        end
        assert (nums.size() == 5 && first_k == 3)
            else flag_error("back-to-back loads did not return five timed records");
        foreach (nums[k]) begin
            assert (nums[k] == slot_t'(k % 4))
                else flag_error("o_rbg_num out of rotation order");
        end
        end_test("slot rotation");

        start_sort(col_a);
        wait_done(n);
        assert (n == SORT_LAT) else flag_error("o_sort_done at the wrong cycle");
        assert (scores_consistent(col_a, o_score))
            else flag_error("scores are not a tie-ordered permutation");
        end_test("single sort");

        // Second start lands in ST_RANK with a new column on the bus
        start_sort(col_a);
        repeat (4) @(negedge i_clk);
        i_data = random_column();
        i_sort_start = 1'b1;
        @(negedge i_clk);
        i_sort_start = 1'b0;
        wait_done(n);
        assert (n + 5 == SORT_LAT) else flag_error("ignored start moved o_sort_done");
        assert (o_score == rank_scores(col_a)) else flag_error("ignored start changed o_score");
        end_test("start during rank");

        // Bring the read slot onto the slot the next sort writes
        while (ref_rd_slot != ref_wr_slot) begin
            @(negedge i_clk);
            i_rbg_load = 1'b1;
            @(negedge i_clk);
            i_rbg_load = 1'b0;
        end
        repeat (3) @(negedge i_clk);
        slot = ref_wr_slot;
        old_rec = ref_mem[slot];
        start_sort(col_a);
        repeat (17) @(negedge i_clk);
        i_rbg_load = 1'b1;
        @(negedge i_clk);
        i_rbg_load = 1'b0;
        while (!o_rbg_load) begin
            @(negedge i_clk);
        end
        assert (o_rbg_num == slot && o_data == old_rec.data
                && o_beam_index == old_rec.index)
            else flag_error("read during a write did not return the old record");
        end_test("read write collision");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
design/beam_sort_pkg.sv
design/rank_lane.sv
design/sort_scatter.sv
design/beam_mem.sv
design/sort_ctrl.sv
design/beam_sort_top.sv
bench/beam_sort_tb.sv

/* run.sh */
#!/bin/sh
# Build the beam sorter testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert --timescale 1ns/1ps --top-module beam_sort_tb \
    -f files.f -o beam_sort_sim \
    && ./obj_dir/beam_sort_sim | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
